// ==== hdl/ksBusPkg.sv ====
`default_nettype none

package ksBusPkg;

   //////////////////////////////
   // Processor bus word
   //////////////////////////////

   // Bus word width
   localparam int busWidth = 36;

   // Big-endian numbering with bit 0 as the MSB
   typedef logic [0:busWidth-1] busWordT;

   //////////////////////////////
   // DMA address fields
   //////////////////////////////

   // Device bits copied straight into the memory address
   localparam int devKeepHi = 0;
   localparam int devKeepLo = 15;

   // Virtual page number that selects the table entry
   localparam int vpnHi = 19;
   localparam int vpnLo = 24;

   // Word number inside the page
   localparam int wordHi = 25;
   localparam int wordLo = 33;

   //////////////////////////////
   // NXM rule
   //////////////////////////////

   // UBA A17 must be zero on every transfer
   localparam int a17Bit = 18;

   // Word and byte select bits
   // Either one set in fast transfer mode is an alignment error
   localparam int wSelBit = 34;
   localparam int bSelBit = 35;

endpackage

`default_nettype wire

// ==== hdl/bridgePagePkg.sv ====
`default_nettype none

package bridgePagePkg;

   //////////////////////////////
   // Page table entry
   //////////////////////////////

   // Virtual pages in the table
   localparam int pageDepth = 64;

   // Physical page number width for 2048 pages
   localparam int ppnWidth = 11;

   // Table index
   typedef logic [0:$clog2(pageDepth)-1] pageIndexT;

   // Internal layout with flags ahead of the PPN
   typedef struct packed
   {
      logic                rpw;   // Force read-pause-write
      logic                e16;   // 16-bit transfers only
      logic                ftm;   // Fast transfer mode
      logic                vld;   // Page valid
      logic [0:ppnWidth-1] ppn;   // Physical page number
   } pageEntryT;

   //////////////////////////////
   // Host register formats
   //////////////////////////////

   // Write word carries flags and PPN in the right half
   localparam int wrFlagHi = 18;
   localparam int wrFlagLo = 21;
   localparam int wrPpnHi  = 25;
   localparam int wrPpnLo  = 35;

   // Read word fields and all other bits read as zero
   localparam int rdFlagHi = 5;
   localparam int rdFlagLo = 8;
   localparam int rdPpnHi  = 16;
   localparam int rdPpnLo  = 26;

   // One host transfer
   typedef struct packed
   {
      logic              write;   // Set for a table write
      pageIndexT         index;   // Entry to access
      ksBusPkg::busWordT data;    // Write word in the write format
   } hostReqT;

endpackage

`default_nettype wire

// ==== hdl/fourPhaseCapture.sv ====
`default_nettype none

module fourPhaseCapture #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    req,
   input  payloadT reqData,
   output logic    ack,
   output logic    valid,
   output payloadT payload,
   input  logic    done
);

   // Handshake phases seen from the responder side
   typedef enum logic [1:0]
   {
      stIdle,
      stHolding,
      stAcking
   } stateT;

   stateT state;

   //////////////////////////////
   // Handshake FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= stIdle;
      end
      else
      begin
         case (state)
            // Only take a new request once ack is back low
            stIdle:
            begin
               if (req)
               begin
                  state <= stHolding;
               end
            end
            // Consumer owns the payload until it signals done
            stHolding:
            begin
               if (done)
               begin
                  state <= stAcking;
               end
            end
            // Return to zero half of the handshake
            stAcking:
            begin
               if (!req)
               begin
                  state <= stIdle;
               end
            end
            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Payload is stable while req is high so take it on entry
   always_ff @(posedge clk)
   begin
      if ((state == stIdle) && req)
      begin
         payload <= reqData;
      end
   end

   // Outputs decode straight from the state register
   assign valid = (state == stHolding);
   assign ack   = (state == stAcking);

endmodule

`default_nettype wire

// ==== hdl/pageTable.sv ====
`default_nettype none

module pageTable (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     wrEn,
   input  bridgePagePkg::pageIndexT wrIndex,
   input  ksBusPkg::busWordT        wrData,
   output ksBusPkg::busWordT        rdWord,
   input  ksBusPkg::busWordT        devAddr,
   output ksBusPkg::busWordT        physAddr,
   output logic                     nxm
);

   import ksBusPkg::*;
   import bridgePagePkg::*;

   // Entry storage
   pageEntryT pageRam [0:pageDepth-1];

   // Page valid bits with every page invalid out of reset
   logic [0:pageDepth-1] vldBits;

   pageEntryT wrEntry;
   pageEntryT hostEntry;
   pageEntryT devEntry;
   pageIndexT virtPage;

   //////////////////////////////
   // Host read/write port
   //////////////////////////////

   // Repack the write word into the internal layout
   assign wrEntry = {wrData[wrFlagHi:wrFlagLo], wrData[wrPpnHi:wrPpnLo]};

   // Table written on the rising edge
   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         pageRam[wrIndex] <= wrEntry;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vldBits <= '0;
      end
      else if (wrEn)
      begin
         vldBits[wrIndex] <= wrEntry.vld;
      end
   end

   // Host view of the addressed entry
   always_comb
   begin
      hostEntry     = pageRam[wrIndex];
      hostEntry.vld = vldBits[wrIndex];
   end

   // Read format puts flags at 5..8 and PPN at 16..26
   always_comb
   begin
      rdWord                    = '0;
      rdWord[rdFlagHi:rdFlagLo] = {hostEntry.rpw, hostEntry.e16, hostEntry.ftm, hostEntry.vld};
      rdWord[rdPpnHi:rdPpnLo]   = hostEntry.ppn;
   end

   //////////////////////////////
   // DMA translation port
   //////////////////////////////

   assign virtPage = devAddr[vpnHi:vpnLo];

   always_comb
   begin
      devEntry     = pageRam[virtPage];
      devEntry.vld = vldBits[virtPage];
   end

   // Upper device bits then physical page then word number
   assign physAddr = {devAddr[devKeepHi:devKeepLo], devEntry.ppn, devAddr[wordHi:wordLo]};

   // Refuse on A17 or an invalid page or a misaligned FTM access
   assign nxm = devAddr[a17Bit] |
                !devEntry.vld |
                (devEntry.ftm & (devAddr[wSelBit] | devAddr[bSelBit]));

endmodule

`default_nettype wire

// ==== hdl/hostRegPort.sv ====
`default_nettype none

module hostRegPort (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid,
   input  bridgePagePkg::hostReqT   request,
   output logic                     done,
   output logic                     wrEn,
   output bridgePagePkg::pageIndexT wrIndex,
   output ksBusPkg::busWordT        wrData,
   input  ksBusPkg::busWordT        rdWord,
   output ksBusPkg::busWordT        rdData
);

   // High once the request on valid has been served
   logic busy;

   //////////////////////////////
   // Request service
   //////////////////////////////

   // Serve in the first valid cycle only
   assign done = valid & !busy;

   // One cycle write strobe
   assign wrEn = done & request.write;

   // Index also drives the table read side
   assign wrIndex = request.index;
   assign wrData  = request.data;

   // Cleared when the capture block drops valid
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy <= 1'b0;
      end
      else if (!valid)
      begin
         busy <= 1'b0;
      end
      else if (done)
      begin
         busy <= 1'b1;
      end
   end

   // Read word held for the host until the next read
   always_ff @(posedge clk)
   begin
      if (done && !request.write)
      begin
         rdData <= rdWord;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/memRequestDriver.sv ====
`default_nettype none

module memRequestDriver (
   input  logic              clk,
   input  logic              rst,
   input  logic              valid,
   input  ksBusPkg::busWordT physAddr,
   input  logic              nxm,
   output logic              done,
   output logic              refused,
   output logic              memReq,
   output ksBusPkg::busWordT memAddr,
   input  logic              memAck
);

   // Memory handshake phases
   typedef enum logic [1:0]
   {
      stIdle,
      stRequest,
      stRelease,
      stFinish
   } stateT;

   stateT state;

   // First valid cycle decisions
   logic refuse;
   logic start;

   assign refuse = (state == stIdle) & valid & nxm;
   assign start  = (state == stIdle) & valid & !nxm;

   //////////////////////////////
   // Memory four-phase FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= stIdle;
      end
      else
      begin
         case (state)
            stIdle:
            begin
               if (start)
               begin
                  state <= stRequest;
               end
            end
            // Hold req until memory acknowledges
            stRequest:
            begin
               if (memAck)
               begin
                  state <= stRelease;
               end
            end
            // Wait for memory to drop ack
            stRelease:
            begin
               if (!memAck)
               begin
                  state <= stFinish;
               end
            end
            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Refused requests finish at once
   assign done   = refuse | (state == stFinish);
   assign memReq = (state == stRequest);

   // NXM status kept for the device until the next request
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         refused <= 1'b0;
      end
      else if (refuse)
      begin
         refused <= 1'b1;
      end
      else if (start)
      begin
         refused <= 1'b0;
      end
   end

   // Translated address stays put for the whole memory cycle
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         memAddr <= physAddr;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/ioBridgePager.sv ====
`default_nettype none

module ioBridgePager (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   hostReq,
   input  bridgePagePkg::hostReqT hostReqData,
   output logic                   hostAck,
   output ksBusPkg::busWordT      hostRdData,
   input  logic                   dmaReq,
   input  ksBusPkg::busWordT      dmaAddr,
   output logic                   dmaAck,
   output logic                   dmaNxm,
   output logic                   memReq,
   output ksBusPkg::busWordT      memAddr,
   input  logic                   memAck
);

   import ksBusPkg::*;
   import bridgePagePkg::*;

   // Host side
   logic      hostValid;
   logic      hostDone;
   hostReqT   hostPayload;
   logic      wrEn;
   pageIndexT wrIndex;
   busWordT   wrData;
   busWordT   rdWord;

   // Device side
   logic    dmaValid;
   logic    dmaDone;
   busWordT dmaPayload;
   busWordT physAddr;
   logic    nxm;

   //////////////////////////////
   // Host register path
   //////////////////////////////

   fourPhaseCapture #(.payloadT(hostReqT)) hostCapture (
      .clk     (clk),
      .rst     (rst),
      .req     (hostReq),
      .reqData (hostReqData),
      .ack     (hostAck),
      .valid   (hostValid),
      .payload (hostPayload),
      .done    (hostDone)
   );

   hostRegPort hostRegPort (
      .clk     (clk),
      .rst     (rst),
      .valid   (hostValid),
      .request (hostPayload),
      .done    (hostDone),
      .wrEn    (wrEn),
      .wrIndex (wrIndex),
      .wrData  (wrData),
      .rdWord  (rdWord),
      .rdData  (hostRdData)
   );

   // Shared by host access and DMA lookup
   pageTable pageTable (
      .clk      (clk),
      .rst      (rst),
      .wrEn     (wrEn),
      .wrIndex  (wrIndex),
      .wrData   (wrData),
      .rdWord   (rdWord),
      .devAddr  (dmaPayload),
      .physAddr (physAddr),
      .nxm      (nxm)
   );

   //////////////////////////////
   // DMA path
   //////////////////////////////

   fourPhaseCapture #(.payloadT(busWordT)) dmaCapture (
      .clk     (clk),
      .rst     (rst),
      .req     (dmaReq),
      .reqData (dmaAddr),
      .ack     (dmaAck),
      .valid   (dmaValid),
      .payload (dmaPayload),
      .done    (dmaDone)
   );

   // Refused status doubles as the device NXM flag
   memRequestDriver memRequestDriver (
      .clk      (clk),
      .rst      (rst),
      .valid    (dmaValid),
      .physAddr (physAddr),
      .nxm      (nxm),
      .done     (dmaDone),
      .refused  (dmaNxm),
      .memReq   (memReq),
      .memAddr  (memAddr),
      .memAck   (memAck)
   );

endmodule

`default_nettype wire

// ==== testbench/ioBridgePagerTb.sv ====
`default_nettype none

module ioBridgePagerTb;

   import ksBusPkg::*;
   import bridgePagePkg::*;

   // Clock period and reset length in cycles
   localparam int clkPeriod   = 20;
   localparam int resetCycles = 8;

   // Upper bound on host and DMA transfers in the whole run
   localparam int txnCount      = 256;
   localparam int watchdogLimit = (resetCycles + 200 * txnCount) * clkPeriod;

   logic    clk;
   logic    rst;
   logic    hostReq;
   hostReqT hostReqData;
   logic    hostAck;
   busWordT hostRdData;
   logic    dmaReq;
   busWordT dmaAddr;
   logic    dmaAck;
   logic    dmaNxm;
   logic    memReq;
   busWordT memAddr;
   logic    memAck;

   // Table model with flags ordered rpw e16 ftm vld
   logic [0:3]  modelFlags [0:pageDepth-1];
   logic [0:10] modelPpn   [0:pageDepth-1];

   // Expected results of the transfer in flight
   logic    hostIsRead;
   busWordT expRead;
   logic    expNxm;
   busWordT expAddr;

   ioBridgePager ioBridgePager_inst (
      .clk         (clk),
      .rst         (rst),
      .hostReq     (hostReq),
      .hostReqData (hostReqData),
      .hostAck     (hostAck),
      .hostRdData  (hostRdData),
      .dmaReq      (dmaReq),
      .dmaAddr     (dmaAddr),
      .dmaAck      (dmaAck),
      .dmaNxm      (dmaNxm),
      .memReq      (memReq),
      .memAddr     (memAddr),
      .memAck      (memAck)
   );

   initial clk = 1'b0;
   always #(clkPeriod / 2) clk = ~clk;

   //////////////////////////////
   // Error reporting
   //////////////////////////////

   task automatic reportMismatch(input string what);
      $display("mismatch at time %0t: %s", $time, what);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1);
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic busWordT randomWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   // Read format puts flags at 5..8 and PPN at 16..26
   function automatic busWordT expectedRead(input pageIndexT idx);
      busWordT w;
      w        = '0;
      w[5:8]   = modelFlags[idx];
      w[16:26] = modelPpn[idx];
      return w;
   endfunction

   // Refused on A17 or an invalid page or FTM with a low address bit set
   function automatic logic expectedNxm(input busWordT addr);
      pageIndexT idx;
      idx = addr[19:24];
      return addr[18] | !modelFlags[idx][3] |
             (modelFlags[idx][2] & (addr[34] | addr[35]));
   endfunction

   // Device bits 0..15 then the PPN then the word field
   function automatic busWordT expectedAddr(input busWordT addr);
      pageIndexT idx;
      idx = addr[19:24];
      return {addr[0:15], modelPpn[idx], addr[25:33]};
   endfunction

   // Write word with chosen flags and PPN and junk in the other bits
   function automatic busWordT pageWord(input logic [0:3] flags, input logic [0:10] ppn);
      busWordT w;
      w          = randomWord();
      w[18:21]   = flags;
      w[25:35]   = ppn;
      return w;
   endfunction

   function automatic busWordT dmaAddress(input pageIndexT idx, input logic a17,
                                          input logic [1:0] lowBits);
      busWordT w;
      w        = randomWord();
      w[18]    = a17;
      w[19:24] = idx;
      w[34:35] = lowBits;
      return w;
   endfunction

   //////////////////////////////
   // Host and DMA transfers
   //////////////////////////////

   task automatic hostTransfer(input logic wr, input pageIndexT idx, input busWordT data);
      @(negedge clk);
      hostIsRead        = !wr;
      expRead           = expectedRead(idx);
      hostReqData.write = wr;
      hostReqData.index = idx;
      hostReqData.data  = data;
      hostReq           = 1'b1;
      while (!hostAck)
      begin
         @(negedge clk);
      end
      hostReq = 1'b0;
      while (hostAck)
      begin
         @(negedge clk);
      end
   endtask

   // Model follows the write once the host sees it done
   task automatic writeEntry(input pageIndexT idx, input busWordT data);
      hostTransfer(1'b1, idx, data);
      modelFlags[idx] = data[18:21];
      modelPpn[idx]   = data[25:35];
   endtask

   task automatic readEntry(input pageIndexT idx);
      hostTransfer(1'b0, idx, '0);
   endtask

   task automatic dmaTransfer(input busWordT addr);
      @(negedge clk);
      expNxm  = expectedNxm(addr);
      expAddr = expectedAddr(addr);
      dmaAddr = addr;
      dmaReq  = 1'b1;
      while (!dmaAck)
      begin
         @(negedge clk);
      end
      dmaReq = 1'b0;
      while (dmaAck)
      begin
         @(negedge clk);
      end
   endtask

   // Memory side answers after 0 to 5 cycles
   initial
   begin
      int holdOff;
      memAck = 1'b0;
      forever
      begin
         @(negedge clk);
         if (memReq)
         begin
            holdOff = $urandom_range(5, 0);
            repeat (holdOff) @(negedge clk);
            memAck = 1'b1;
            while (memReq)
            begin
               @(negedge clk);
            end
            memAck = 1'b0;
         end
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   hostReadCheck: assert property (@(posedge clk) disable iff (rst)
      ($rose(hostAck) && hostIsRead) |-> (hostRdData == expRead))
      else reportMismatch($sformatf("host read %h, model %h", hostRdData, expRead));

   nxmCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(dmaAck) |-> (dmaNxm == expNxm))
      else reportMismatch($sformatf("dmaNxm %b, model %b", dmaNxm, expNxm));

   memAddrCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(memReq) |-> (memAddr == expAddr))
      else reportMismatch($sformatf("memAddr %h, model %h", memAddr, expAddr));

   // Back-pressure keeps the memory request steady
   holdCheck: assert property (@(posedge clk) disable iff (rst)
      (memReq && !memAck) |=> (memReq && $stable(memAddr)))
      else reportFailure("memReq or memAddr changed while memAck was still low");

   // Device ack waits for the whole memory handshake including the ack release
   ackOrderCheck: assert property (@(posedge clk) disable iff (rst)
      (memReq || memAck) |-> !dmaAck)
      else reportFailure("dmaAck rose before the memory handshake finished");

   refuseCheck: assert property (@(posedge clk) disable iff (rst)
      (dmaReq && expNxm) |-> !memReq)
      else reportFailure("a refused DMA request started a memory request");

   hostLatencyCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(hostReq) |-> ##2 $rose(hostAck))
      else reportFailure("hostAck did not rise two cycles after hostReq");

   nxmLatencyCheck: assert property (@(posedge clk) disable iff (rst)
      ($rose(dmaReq) && expNxm) |-> ##2 ($rose(dmaAck) && dmaNxm))
      else reportFailure("refused dmaAck did not rise two cycles after dmaReq");

   // Return to zero half of both device side handshakes
   hostReleaseCheck: assert property (@(posedge clk) disable iff (rst)
      $fell(hostReq) |=> !hostAck)
      else reportFailure("hostAck stayed high after hostReq fell");

   dmaReleaseCheck: assert property (@(posedge clk) disable iff (rst)
      $fell(dmaReq) |=> !dmaAck)
      else reportFailure("dmaAck stayed high after dmaReq fell");

   //////////////////////////////
   // Watchdog
   //////////////////////////////

   initial
   begin
      #(watchdogLimit);
      reportFailure("watchdog expired before all transfers finished");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      void'($urandom(32'h04e8668a));
      rst         = 1'b1;
      hostReq     = 1'b0;
      hostReqData = '0;
      dmaReq      = 1'b0;
      dmaAddr     = '0;
      hostIsRead  = 1'b0;
      expRead     = '0;
      expNxm      = 1'b0;
      expAddr     = '0;
      for (int i = 0; i < pageDepth; i++)
      begin
         modelFlags[i] = '0;
         modelPpn[i]   = '0;
      end
      repeat (resetCycles) @(negedge clk);
      rst = 1'b0;

      // Every page invalid out of reset with A17 clear
      for (int i = 0; i < pageDepth; i++)
      begin
         dmaTransfer(dmaAddress(pageIndexT'(i), 1'b0, 2'($urandom())));
      end

      // Fill the whole table and read it back
      for (int i = 0; i < pageDepth; i++)
      begin
         writeEntry(pageIndexT'(i), randomWord());
      end
      for (int i = 0; i < pageDepth; i++)
      begin
         readEntry(pageIndexT'(i));
      end

      // Valid page with FTM clear and then A17 on the same page
      writeEntry(6'd5, pageWord(4'b0001, 11'($urandom())));
      dmaTransfer(dmaAddress(6'd5, 1'b0, 2'($urandom())));
      dmaTransfer(dmaAddress(6'd5, 1'b1, 2'b00));

      // Invalid page
      writeEntry(6'd6, pageWord(4'b1100, 11'($urandom())));
      dmaTransfer(dmaAddress(6'd6, 1'b0, 2'b00));

      // FTM page over all four low bit patterns
      writeEntry(6'd7, pageWord(4'b0011, 11'($urandom())));
      for (int i = 0; i < 4; i++)
      begin
         dmaTransfer(dmaAddress(6'd7, 1'b0, 2'(i)));
      end

      // Random mix over the filled table with A17 about one in four
      for (int i = 0; i < 32; i++)
      begin
         dmaTransfer(dmaAddress(6'($urandom()), ($urandom_range(3, 0) == 0),
                                2'($urandom())));
      end

      // Host writes to the upper half while DMA hits the lower pages
      for (int k = 0; k < 8; k++)
      begin
         fork
            writeEntry(pageIndexT'(32 + k), randomWord());
            dmaTransfer(dmaAddress(pageIndexT'(k), 1'b0, 2'($urandom())));
         join
      end

      repeat (4) @(negedge clk);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ioBridgePager.f ====
hdl/ksBusPkg.sv
hdl/bridgePagePkg.sv
hdl/fourPhaseCapture.sv
hdl/pageTable.sv
hdl/hostRegPort.sv
hdl/memRequestDriver.sv
hdl/ioBridgePager.sv
testbench/ioBridgePagerTb.sv

// ==== Bender.yml ====
package:
  name: ioBridgePager

sources:
  - hdl/ksBusPkg.sv
  - hdl/bridgePagePkg.sv
  - hdl/fourPhaseCapture.sv
  - hdl/pageTable.sv
  - hdl/hostRegPort.sv
  - hdl/memRequestDriver.sv
  - hdl/ioBridgePager.sv
  - target: test
    files:
      - testbench/ioBridgePagerTb.sv
